// File: list.f
rtl/video_pkg.sv
rtl/video_if.sv
rtl/cam_capture.sv
rtl/async_fifo.sv
rtl/err_stretch.sv
rtl/line_ctrl.sv
rtl/line_buffer.sv
testbench/tb_line_buffer.sv

// File: run.sh
#!/bin/sh
# Build the line buffer testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
        --top-module tb_line_buffer -Mdir "$BUILD_DIR" -f list.f; then
    echo "Build failed."
    exit 1
fi

"$BUILD_DIR/Vtb_line_buffer" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulator exited with status $sim_status."
fi

if grep -F -q "*** TEST PASSED ***" "$LOG"; then
    echo "Simulation passed."
    exit 0
else
    echo "Simulation failed, see $LOG."
    exit 1
fi

// File: testbench/tb_line_buffer.sv
`timescale 1ns/1ps

module tb_line_buffer import video_pkg::*; ();

    localparam int H_T         = 32;                   // Small test frame.
    localparam int V_T         = 4;
    localparam int LONG_PIX    = (1 << FIFO_AW) + 64;  // Overruns the FIFO.
    localparam int ACQ_TIMEOUT = 200;                  // In rclk cycles.
    localparam int ERR_SLACK   = 50;                   // In camera clocks.

    logic             rclk;
    logic             rstn;
    logic             trig;
    logic             read_en;
    logic [48:0]      cam_pack;
    logic             acquire;
    logic [PIX_W-1:0] cam_data;
    logic [10:0]      cam_row;
    logic             error;

    logic             cam_clk;
    logic             cam_vs;
    logic             cam_de;
    logic [7:0]       cam_r;
    logic [7:0]       cam_g;
    logic [7:0]       cam_b;
    logic [21:0]      cam_rsv;

    integer           seed;
    logic [15:0]      exp_q[$];                        // RGB565 words still to be read.
    int               sent_cnt;
    logic             expect_idle;
    logic             ovf_phase;

    always #10 rclk = ~rclk;
    always #7 cam_clk = ~cam_clk;

    always_comb begin
        cam_pack                  = '0;
        cam_pack[PK_CLK]          = cam_clk;
        cam_pack[PK_VSYNC]        = cam_vs;
        cam_pack[PK_DE]           = cam_de;
        cam_pack[45:24]           = cam_rsv;
        cam_pack[PK_R_LSB +: 8]   = cam_r;
        cam_pack[PK_G_LSB +: 8]   = cam_g;
        cam_pack[PK_B_LSB +: 8]   = cam_b;
    end

    line_buffer #(
        .H_ACT (H_T),
        .V_ACT (V_T)
    ) i_line_buffer (
        .rclk     (rclk),
        .rstn     (rstn),
        .trig     (trig),
        .cam_pack (cam_pack),
        .acquire  (acquire),
        .read_en  (read_en),
        .cam_data (cam_data),
        .cam_row  (cam_row),
        .error    (error)
    );

    // Nothing reaches the reader while no capture is armed.
    assert property (@(posedge rclk) disable iff (!rstn) !(expect_idle && acquire))
        else report_mismatch("acquire", 32'd0, 32'(acquire));
    assert property (@(posedge rclk) disable iff (!rstn) !(expect_idle && cam_row != '0))
        else report_mismatch("cam_row", 32'd0, 32'(cam_row));
    assert property (@(posedge rclk) disable iff (!rstn) cam_row < 11'(V_T))
        else report_problem("cam_row counted past the last line of the frame.");
    assert property (@(posedge cam_clk) disable iff (!rstn) !(error && !ovf_phase))
        else report_mismatch("error", 32'd0, 32'(error));

    task automatic fail_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped at the first failure.");
    endtask

    task automatic report_mismatch(input string sig, input logic [31:0] exp_val,
                                   input logic [31:0] act_val);
        $display("[ERROR] %0t ns: %s expected 0x%0h, got 0x%0h", $time, sig, exp_val, act_val);
        fail_run();
    endtask

    task automatic report_problem(input string what);
        $display("%0t ns: %s", $time, what);
        fail_run();
    endtask

    // Top bits of each colour.
    function automatic logic [15:0] rgb565(input logic [7:0] r, input logic [7:0] g,
                                           input logic [7:0] b);
        return {r[7:3], g[7:2], b[7:3]};
    endfunction

    task automatic cam_step();
        @(posedge cam_clk);
        #2;
    endtask

    task automatic rclk_step();
        @(posedge rclk);
        #2;
    endtask

    task automatic pulse_trig();
        rclk_step();
        trig = 1'b1;
        rclk_step();
        trig = 1'b0;
    endtask

    // Read strobes while idle must leave the counters at zero.
    task automatic read_while_idle();
        read_en = 1'b1;
        repeat (4) rclk_step();
        read_en = 1'b0;
        repeat (4) rclk_step();
    endtask

    // Vsync, blanking, then n_lines bursts of n_pix active pixels.
    task automatic send_frame(input int n_lines, input int n_pix, input bit keep);
        logic [31:0] rnd;
        sent_cnt = 0;
        cam_step();
        cam_vs = 1'b1;
        cam_step();
        cam_step();
        cam_vs = 1'b0;
        repeat (12) cam_step();
        for (int l = 0; l < n_lines; l++) begin
            for (int p = 0; p < n_pix; p++) begin
                cam_step();
                rnd     = $random(seed);
                cam_r   = rnd[23:16];
                cam_g   = rnd[15:8];
                cam_b   = rnd[7:0];
                rnd     = $random(seed);
                cam_rsv = rnd[21:0];                   // Reserved bits carry noise.
                cam_de  = 1'b1;
                sent_cnt++;
                if (keep) begin
                    exp_q.push_back(rgb565(cam_r, cam_g, cam_b));
                end
            end
            cam_step();
            cam_de  = 1'b0;
            cam_rsv = '0;
            repeat (8) cam_step();                     // Horizontal blanking.
        end
    endtask

    task automatic read_line(input int line);
        int          wait_cnt;
        logic [15:0] exp_pix;
        wait_cnt = 0;
        do begin
            rclk_step();
            wait_cnt++;
            if (wait_cnt > ACQ_TIMEOUT) begin
                report_problem("Timeout waiting for acquire while a line was being sent.");
            end
        end while (acquire !== 1'b1);
        assert (sent_cnt >= (line + 1) * H_T)
            else report_problem("acquire rose before a whole line was sent.");
        assert (cam_row === 11'(line))
            else report_mismatch("cam_row", 32'(line), 32'(cam_row));
        read_en = 1'b1;
        for (int i = 0; i < H_T; i++) begin
            rclk_step();
            if (i == H_T - 1) begin
                read_en = 1'b0;                        // Burst ends after H_T reads.
            end
            if (exp_q.size() == 0) begin
                report_problem("More words read than pixels were sent.");
            end
            exp_pix = exp_q.pop_front();
            assert (cam_data === exp_pix)
                else report_mismatch("cam_data", 32'(exp_pix), 32'(cam_data));
        end
        repeat (3) rclk_step();
        assert (cam_row === 11'((line + 1) % V_T))
            else report_mismatch("cam_row", 32'((line + 1) % V_T), 32'(cam_row));
    endtask

    task automatic read_frame();
        for (int line = 0; line < V_T; line++) begin
            read_line(line);
        end
    endtask

    task automatic capture_frame();
        pulse_trig();
        fork
            send_frame(V_T, H_T, 1'b1);
            read_frame();
        join
        assert (exp_q.size() == 0)
            else report_problem("Pixels were left over after the frame was read.");
    endtask

    // Flush the full FIFO with a vsync and time the error level.
    task automatic time_error_hold();
        int n;
        cam_step();
        cam_vs = 1'b1;
        cam_step();
        cam_vs = 1'b0;
        n = 1;
        while (error === 1'b1) begin
            cam_step();
            n++;
            if (n > ERR_TICK + ERR_SLACK) begin
                report_problem("error stayed high long after the FIFO was flushed.");
            end
        end
        assert (n >= ERR_TICK - 2)
            else report_mismatch("error hold clocks", 32'(ERR_TICK), 32'(n));
    endtask

    initial begin
        seed        = 32'h6a7d;
        rclk        = 1'b0;
        cam_clk     = 1'b0;
        rstn        = 1'b0;
        trig        = 1'b0;
        read_en     = 1'b0;
        cam_vs      = 1'b0;
        cam_de      = 1'b0;
        cam_r       = '0;
        cam_g       = '0;
        cam_b       = '0;
        cam_rsv     = '0;
        sent_cnt    = 0;
        expect_idle = 1'b1;
        ovf_phase   = 1'b0;

        repeat (8) @(posedge rclk);
        #2;
        rstn = 1'b1;
        repeat (4) rclk_step();

        assert (acquire === 1'b0) else report_mismatch("acquire", 32'd0, 32'(acquire));
        assert (error === 1'b0) else report_mismatch("error", 32'd0, 32'(error));
        assert (cam_row === '0) else report_mismatch("cam_row", 32'd0, 32'(cam_row));

        // No trigger yet, so this frame is not stored.
        send_frame(V_T, H_T, 1'b0);
        read_while_idle();
        repeat (10) rclk_step();

        expect_idle = 1'b0;
        capture_frame();

        // Back in idle, the next frame is ignored.
        repeat (2) rclk_step();
        expect_idle = 1'b1;
        send_frame(V_T, H_T, 1'b0);
        read_while_idle();
        repeat (10) rclk_step();

        expect_idle = 1'b0;
        capture_frame();

        // Armed but never read, so the FIFO overflows.
        ovf_phase = 1'b1;
        pulse_trig();
        send_frame(1, LONG_PIX, 1'b0);
        assert (error === 1'b1) else report_mismatch("error", 32'd1, 32'(error));
        time_error_hold();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule : tb_line_buffer

// File: rtl/line_buffer.sv
`timescale 1ns/1ps

module line_buffer import video_pkg::*; #(
    parameter int H_ACT = H_ACT_DEF,
    parameter int V_ACT = V_ACT_DEF
) (
    input  logic             rclk,
    input  logic             rstn,
    input  logic             trig,
    input  logic [48:0]      cam_pack,

    output logic             acquire,
    input  logic             read_en,
    output logic [PIX_W-1:0] cam_data,
    output logic [10:0]      cam_row,

    output logic             error
);

    video_if vid ();

    logic cam_clk;
    logic cap_en;
    logic fifo_rst;
    logic full;
    logic almost_empty;
    logic ready;
    logic cam_rst_meta;
    logic cam_rstn;

    cam_capture i_cam_capture (
        .cam_pack (cam_pack),
        .cap_en   (cap_en),
        .cam_clk  (cam_clk),
        .vid      (vid)
    );

    // Each frame start flushes both FIFO sides.
    assign fifo_rst = vid.vsync | ~rstn;

    async_fifo #(
        .AE_LVL (H_ACT)
    ) i_async_fifo (
        .wr_clk       (cam_clk),
        .wr_rst       (fifo_rst),
        .wr_en        (vid.de),
        .wr_data      (vid.pix),
        .full         (full),
        .rd_clk       (rclk),
        .rd_rst       (fifo_rst),
        .rd_en        (read_en),
        .rd_data      (cam_data),
        .almost_empty (almost_empty)
    );

    assign ready   = ~almost_empty;
    assign acquire = ready;                   // A whole line is waiting.

    // Reset for the camera domain, released on cam_clk.
    always_ff @(posedge cam_clk or negedge rstn) begin
        if (!rstn) begin
            cam_rst_meta <= 1'b0;
            cam_rstn     <= 1'b0;
        end else begin
            cam_rst_meta <= 1'b1;
            cam_rstn     <= cam_rst_meta;
        end
    end

    err_stretch i_err_stretch (
        .clk  (cam_clk),
        .rstn (cam_rstn),
        .trip (full),
        .err  (error)
    );

    line_ctrl #(
        .H_ACT (H_ACT),
        .V_ACT (V_ACT)
    ) i_line_ctrl (
        .rclk    (rclk),
        .rstn    (rstn),
        .trig    (trig),
        .vsync   (vid.vsync),
        .ready   (ready),
        .read_en (read_en),
        .cap_en  (cap_en),
        .row     (cam_row)
    );

endmodule : line_buffer

// File: rtl/line_ctrl.sv
`timescale 1ns/1ps

module line_ctrl import video_pkg::*; #(
    parameter int H_ACT = H_ACT_DEF,
    parameter int V_ACT = V_ACT_DEF
) (
    input  logic        rclk,
    input  logic        rstn,
    input  logic        trig,
    input  logic        vsync,
    input  logic        ready,
    input  logic        read_en,
    output logic        cap_en,
    output logic [10:0] row
);

    localparam logic [1:0] ST_IDLE       = 2'd0;
    localparam logic [1:0] ST_WAIT_VSYNC = 2'd1;
    localparam logic [1:0] ST_WAIT_CAM   = 2'd2;
    localparam logic [1:0] ST_READ       = 2'd3;

    logic [1:0]         state;
    logic               trig_flag;
    logic               vsync_flag;
    logic               read_en_d;
    logic               read_en_dd;
    logic [FIFO_AW-1:0] col;
    logic               col_end;
    logic               row_end;
    logic               line_done;

    assign col_end   = (col == FIFO_AW'(H_ACT - 1));
    assign row_end   = (row == 11'(V_ACT - 1));
    assign line_done = read_en_dd & ~read_en_d & ~read_en; // Burst ended two cycles ago.
    assign cap_en    = (state == ST_WAIT_CAM) || (state == ST_READ);

    // Trigger is caught asynchronously and dropped once we leave idle.
    always_ff @(posedge rclk or posedge trig or negedge rstn) begin
        if (!rstn) begin
            trig_flag <= 1'b0;
        end else if (trig) begin
            trig_flag <= 1'b1;
        end else if (state != ST_IDLE) begin
            trig_flag <= 1'b0;
        end
    end

    // Vsync only counts while we are waiting for it, a stale one is dropped.
    always_ff @(posedge rclk or posedge vsync or negedge rstn) begin
        if (!rstn) begin
            vsync_flag <= 1'b0;
        end else if (vsync) begin
            vsync_flag <= 1'b1;
        end else if (state != ST_WAIT_VSYNC) begin
            vsync_flag <= 1'b0;
        end
    end

    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            read_en_d  <= 1'b0;
            read_en_dd <= 1'b0;
        end else begin
            read_en_d  <= read_en;
            read_en_dd <= read_en_d;
        end
    end

    // Column and row counters.
    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            col <= '0;
            row <= '0;
        end else if (state == ST_IDLE) begin
            col <= '0;                        // Held while idle.
            row <= '0;
        end else begin
            if (read_en) begin
                col <= col_end ? '0 : col + 1'b1;
            end
            if (line_done) begin
                row <= row_end ? '0 : row + 1'b1;
            end
        end
    end

    // Capture FSM.
    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (trig_flag) begin
                        state <= ST_WAIT_VSYNC;
                    end
                end
                ST_WAIT_VSYNC: begin
                    if (vsync_flag) begin
                        state <= ST_WAIT_CAM;
                    end
                end
                ST_WAIT_CAM: begin
                    if (ready) begin
                        state <= ST_READ;     // A full line is buffered.
                    end
                end
                default: begin
                    if (read_en && col_end) begin
                        state <= row_end ? ST_IDLE : ST_WAIT_CAM;
                    end
                end
            endcase
        end
    end

endmodule : line_ctrl

// File: rtl/err_stretch.sv
`timescale 1ns/1ps

module err_stretch import video_pkg::*; (
    input  logic clk,
    input  logic rstn,
    input  logic trip,
    output logic err
);

    logic [$clog2(ERR_TICK + 1)-1:0] cnt;

    // Reload on every trip, count down once it is gone.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cnt <= '0;
        end else if (trip) begin
            cnt <= $bits(cnt)'(ERR_TICK);
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    assign err = (cnt != '0);                 // Held for ERR_TICK clocks after trip.

endmodule : err_stretch

// File: rtl/async_fifo.sv
`timescale 1ns/1ps

module async_fifo import video_pkg::*; #(
    parameter int AE_LVL = 16
) (
    input  logic             wr_clk,
    input  logic             wr_rst,
    input  logic             wr_en,
    input  logic [PIX_W-1:0] wr_data,
    output logic             full,

    input  logic             rd_clk,
    input  logic             rd_rst,
    input  logic             rd_en,
    output logic [PIX_W-1:0] rd_data,
    output logic             almost_empty
);

    logic [PIX_W-1:0] mem [0:(1 << FIFO_AW) - 1];

    // Write side pointers and the read pointer seen from there.
    logic [FIFO_AW:0] wbin;
    logic [FIFO_AW:0] wbin_nxt;
    logic [FIFO_AW:0] wgray;
    logic [FIFO_AW:0] rgray_w1;
    logic [FIFO_AW:0] rgray_w2;
    logic             wr_ok;

    // Read side pointers and the write pointer seen from there.
    logic [FIFO_AW:0] rbin;
    logic [FIFO_AW:0] rbin_nxt;
    logic [FIFO_AW:0] rgray;
    logic [FIFO_AW:0] wgray_r1;
    logic [FIFO_AW:0] wgray_r2;
    logic [FIFO_AW:0] wbin_r;
    logic [FIFO_AW:0] level;
    logic             empty;
    logic             rd_ok;

    function automatic logic [FIFO_AW:0] gray2bin(input logic [FIFO_AW:0] g);
        logic [FIFO_AW:0] b;
        b[FIFO_AW] = g[FIFO_AW];
        for (int i = FIFO_AW - 1; i >= 0; i--) begin
            b[i] = b[i + 1] ^ g[i];
        end
        return b;
    endfunction

    // Write clock domain.
    assign wbin_nxt = wbin + 1'b1;

    // Full when the top two Gray bits differ and the rest match.
    assign full  = (wgray == {~rgray_w2[FIFO_AW:FIFO_AW-1], rgray_w2[FIFO_AW-2:0]});
    assign wr_ok = wr_en & ~full;             // Writes to a full FIFO are dropped.

    always_ff @(posedge wr_clk) begin
        if (wr_ok) begin
            mem[wbin[FIFO_AW-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge wr_clk or posedge wr_rst) begin
        if (wr_rst) begin
            wbin  <= '0;
            wgray <= '0;
        end else if (wr_ok) begin
            wbin  <= wbin_nxt;
            wgray <= wbin_nxt ^ (wbin_nxt >> 1);
        end
    end

    always_ff @(posedge wr_clk or posedge wr_rst) begin
        if (wr_rst) begin
            rgray_w1 <= '0;
            rgray_w2 <= '0;
        end else begin
            rgray_w1 <= rgray;                // Two-flop synchronizer.
            rgray_w2 <= rgray_w1;
        end
    end

    // Read clock domain.
    assign rbin_nxt = rbin + 1'b1;
    assign empty    = (rgray == wgray_r2);
    assign rd_ok    = rd_en & ~empty;         // Reads when empty are ignored.

    always_ff @(posedge rd_clk or posedge rd_rst) begin
        if (rd_rst) begin
            wgray_r1 <= '0;
            wgray_r2 <= '0;
        end else begin
            wgray_r1 <= wgray;
            wgray_r2 <= wgray_r1;
        end
    end

    always_ff @(posedge rd_clk or posedge rd_rst) begin
        if (rd_rst) begin
            rbin  <= '0;
            rgray <= '0;
        end else if (rd_ok) begin
            rbin  <= rbin_nxt;
            rgray <= rbin_nxt ^ (rbin_nxt >> 1);
        end
    end

    always_ff @(posedge rd_clk) begin
        if (rd_ok) begin
            rd_data <= mem[rbin[FIFO_AW-1:0]]; // Valid the cycle after rd_en.
        end
    end

    // Fill level from the synchronized write pointer.
    assign wbin_r       = gray2bin(wgray_r2);
    assign level        = wbin_r - rbin;
    assign almost_empty = (level < (FIFO_AW + 1)'(AE_LVL));

endmodule : async_fifo

// File: rtl/cam_capture.sv
`timescale 1ns/1ps

module cam_capture import video_pkg::*; (
    input  logic [48:0] cam_pack,
    input  logic        cap_en,
    output logic        cam_clk,
    video_if.src        vid
);

    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
    logic       de_raw;

    // Split the bus at the package bit positions.
    assign cam_clk   = cam_pack[PK_CLK];
    assign vid.vsync = cam_pack[PK_VSYNC];
    assign de_raw    = cam_pack[PK_DE];

    assign red   = cam_pack[PK_R_LSB +: 8];
    assign green = cam_pack[PK_G_LSB +: 8];
    assign blue  = cam_pack[PK_B_LSB +: 8];

    // RGB888 to RGB565, keep the top bits of each colour.
    assign vid.pix = {red[7:3], green[7:2], blue[7:3]};

    // Only pixels after the armed vsync go into the FIFO.
    assign vid.de = de_raw & cap_en;

endmodule : cam_capture

// File: rtl/video_if.sv
`timescale 1ns/1ps

// Camera-domain pixel stream after unpacking and colour conversion.
interface video_if import video_pkg::*; ();

    logic             vsync;                  // Frame start, active high.
    logic             de;                     // Gated write strobe.
    logic [PIX_W-1:0] pix;                    // RGB565 pixel.

    modport src (
        output vsync,
        output de,
        output pix
    );

    modport snk (
        input  vsync,
        input  de,
        input  pix
    );

endinterface : video_if

// File: rtl/video_pkg.sv
package video_pkg;

    // Default frame geometry.
    localparam int H_ACT_DEF = 1280;          // Active pixels per line.
    localparam int V_ACT_DEF = 720;           // Active lines per frame.

    // FIFO holds one complete line at the default width.
    localparam int FIFO_AW   = 11;            // 2048 words.
    localparam int PIX_W     = 16;            // RGB565 word.

    // Error level hold time, in camera clocks.
    localparam int ERR_TICK  = 100000;

    // Camera bus layout.
    // Bits 45 down to 24 are reserved and carry nothing we use.
    localparam int PK_CLK    = 48;            // Pixel clock.
    localparam int PK_VSYNC  = 47;            // Frame start pulse.
    localparam int PK_DE     = 46;            // Active pixel strobe.
    localparam int PK_R_LSB  = 16;            // Red byte.
    localparam int PK_G_LSB  = 8;             // Green byte.
    localparam int PK_B_LSB  = 0;             // Blue byte.

endpackage : video_pkg
